/* hdl/fetch_pkg.sv */
package fetch_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  // data word width that the parcel union relies on
  localparam int xlen        = 32;
  localparam int parcel_size = 32;
  localparam int half_size   = parcel_size / 2;

  // entries in both the pc queue and the response buffer
  localparam int queue_depth = 3;

  ////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////

  // two 16-bit halves of one fetched word
  typedef struct packed {
    logic [half_size-1:0] hi;
    logic [half_size-1:0] lo;
  } parcel_halves_t;

  // same word seen as one parcel or as two halves
  typedef union packed {
    logic [parcel_size-1:0] full;
    parcel_halves_t         half;
  } parcel_u;

  // bit 0 for the low half and bit 1 for the high half
  typedef logic [1:0] parcel_valid_t;

  // requested pc with its valid flag
  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
  } pc_entry_t;

endpackage

/* hdl/bus_pkg.sv */
package bus_pkg;

  ////////////////////////////////////////////////////////////
  // privilege levels
  ////////////////////////////////////////////////////////////

  // encoding as in the privileged spec
  typedef enum logic [1:0] {
    prv_u = 2'b00,
    prv_s = 2'b01,
    prv_h = 2'b10,
    prv_m = 2'b11
  } prv_t;

  ////////////////////////////////////////////////////////////
  // address attributes
  ////////////////////////////////////////////////////////////

  // value of the top address bit that marks an uncached region
  localparam logic uncached_msb_note = 1'b1;

endpackage

/* hdl/fetch_if.sv */
////////////////////////////////////////////////////////////
// pc queue traffic
////////////////////////////////////////////////////////////

interface fetch_q_if;
  // one pc pushed per accepted request
  logic                       push;
  logic [fetch_pkg::xlen-1:0] push_pc;
  // consumer side
  logic                       pop;
  logic                       flush;
  fetch_pkg::pc_entry_t       head;
  // third entry taken
  logic                       full;

  modport req (output push, output push_pc, output flush, input full);
  modport queue (
    input  push,
    input  push_pc,
    input  pop,
    input  flush,
    output head,
    output full
  );
  modport cons (output pop, input head);
endinterface

////////////////////////////////////////////////////////////
// response buffer traffic
////////////////////////////////////////////////////////////

interface fetch_rsp_if;
  // one write per live rack
  logic                       write;
  logic [fetch_pkg::xlen-1:0] write_word;
  logic                       pop;
  logic                       flush;
  // registered head of the buffer
  logic                       head_valid;
  logic [fetch_pkg::xlen-1:0] head_word;

  modport req (output write, output write_word, output flush);
  modport buffer (
    input  write,
    input  write_word,
    input  pop,
    input  flush,
    output head_valid,
    output head_word
  );
  modport cons (output pop, input head_valid, input head_word);
endinterface

/* hdl/bus_request.sv */
module bus_request #(
  parameter int phys_addr_size = 32
) (
  input  logic                       clk,
  input  logic                       rstn,
  // cpu side
  input  logic [fetch_pkg::xlen-1:0] if_nxt_pc,
  input  logic                       if_flush,
  input  logic                       dcflush_rdy,
  input  bus_pkg::prv_t              st_prv,
  output logic                       if_stall_nxt_pc,
  // bus side
  output logic                       biu_stb,
  input  logic                       biu_stb_ack,
  output logic [phys_addr_size-1:0]  biu_adri,
  input  logic                       biu_rack,
  input  logic [fetch_pkg::xlen-1:0] biu_do,
  output logic                       biu_is_cacheable,
  output bus_pkg::prv_t              biu_prv,
  // queues
  fetch_q_if.req                     pcq,
  fetch_rsp_if.req                   rsp
);

  // room for a few back-to-back flushes with racks still pending
  localparam int cnt_w = $clog2(4 * fetch_pkg::queue_depth + 1);

  logic                       accept;
  logic                       rack_live;
  logic                       rack_drop;
  logic [cnt_w-1:0]           out_cnt;
  logic [cnt_w-1:0]           drop_cnt;
  logic [fetch_pkg::xlen-1:0] adr_ext;

  ////////////////////////////////////////////////////////////
  // request issue
  ////////////////////////////////////////////////////////////

  // no issue while flushing or with the pc queue full
  assign biu_stb  = dcflush_rdy & ~if_flush & ~pcq.full;
  assign accept   = biu_stb & biu_stb_ack;
  assign biu_adri = if_nxt_pc[phys_addr_size-1:0];

  // cpu keeps the same pc until it is taken
  assign if_stall_nxt_pc = ~accept;

  // top address bit selects the uncached region
  assign biu_is_cacheable = biu_adri[phys_addr_size-1] != bus_pkg::uncached_msb_note;
  assign biu_prv          = st_prv;

  // pc queue holds the bus address zero-extended
  always_comb begin
    adr_ext = '0;
    adr_ext[phys_addr_size-1:0] = biu_adri;
  end

  assign pcq.push    = accept;
  assign pcq.push_pc = adr_ext;
  assign pcq.flush   = if_flush;

  ////////////////////////////////////////////////////////////
  // responses
  ////////////////////////////////////////////////////////////

  // in-order racks put the flushed ones first
  assign rack_drop = biu_rack & (drop_cnt != '0);
  assign rack_live = biu_rack & (drop_cnt == '0);

  assign rsp.write      = rack_live & ~if_flush;
  assign rsp.write_word = biu_do;
  assign rsp.flush      = if_flush;

  // live and flushed requests in flight
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      out_cnt  <= '0;
      drop_cnt <= '0;
    end else if (if_flush) begin
      // everything still in flight becomes a drop
      out_cnt  <= '0;
      drop_cnt <= drop_cnt + out_cnt - cnt_w'(biu_rack);
    end else begin
      out_cnt  <= out_cnt + cnt_w'(accept) - cnt_w'(rack_live);
      drop_cnt <= drop_cnt - cnt_w'(rack_drop);
    end
  end

endmodule

/* hdl/pc_queue.sv */
module pc_queue (
  input logic     clk,
  input logic     rstn,
  fetch_q_if.queue q
);

  localparam int depth = fetch_pkg::queue_depth;

  logic [depth-1:0]           vld;
  logic [fetch_pkg::xlen-1:0] pc_r [depth];
  fetch_pkg::pc_entry_t       nxt  [depth];

  ////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////

  always_comb begin
    logic placed;
    placed = 1'b0;
    // shift down on pop
    for (int i = 0; i < depth - 1; i++) begin
      if (q.pop) begin
        nxt[i] = '{valid: vld[i+1], pc: pc_r[i+1]};
      end else begin
        nxt[i] = '{valid: vld[i], pc: pc_r[i]};
      end
    end
    if (q.pop) begin
      nxt[depth-1] = '{valid: 1'b0, pc: pc_r[depth-1]};
    end else begin
      nxt[depth-1] = '{valid: vld[depth-1], pc: pc_r[depth-1]};
    end
    // push lands in first free slot after the shift
    if (q.push) begin
      for (int i = 0; i < depth; i++) begin
        if (!placed && !nxt[i].valid) begin
          nxt[i] = '{valid: 1'b1, pc: q.push_pc};
          placed = 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////

  // valid flags
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      vld <= '0;
    end else if (q.flush) begin
      vld <= '0;
    end else begin
      for (int i = 0; i < depth; i++) begin
        vld[i] <= nxt[i].valid;
      end
    end
  end

  // pc values
  always_ff @(posedge clk) begin
    for (int i = 0; i < depth; i++) begin
      pc_r[i] <= nxt[i].pc;
    end
  end

  // head straight from the flops
  assign q.head = '{valid: vld[0], pc: pc_r[0]};
  assign q.full = vld[depth-1];

endmodule

/* hdl/response_buffer.sv */
module response_buffer (
  input logic         clk,
  input logic         rstn,
  fetch_rsp_if.buffer rsp
);

  localparam int depth = fetch_pkg::queue_depth;
  localparam int idx_w = $clog2(depth + 1);

  logic [depth-1:0]           vld;
  logic [fetch_pkg::xlen-1:0] word [depth];
  logic [idx_w-1:0]           cnt;
  logic [idx_w-1:0]           wr_idx;

  ////////////////////////////////////////////////////////////
  // fill level
  ////////////////////////////////////////////////////////////

  // valid bits stay packed from entry 0 up
  always_comb begin
    cnt = '0;
    for (int i = 0; i < depth; i++) begin
      cnt = cnt + idx_w'(vld[i]);
    end
  end

  // slot for a new word once the pop has shifted
  assign wr_idx = cnt - idx_w'(rsp.pop);

  ////////////////////////////////////////////////////////////
  // valid bits
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      vld <= '0;
    end else if (rsp.flush) begin
      vld <= '0;
    end else begin
      case ({rsp.write, rsp.pop})
        // write only adds one entry
        2'b10: vld <= {vld[depth-2:0], 1'b1};
        // pop only drops one entry
        2'b01: vld <= vld >> 1;
        // one in and one out keeps the level
        default: vld <= vld;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // data
  ////////////////////////////////////////////////////////////

  // write after the shift so it wins on the same slot
  always_ff @(posedge clk) begin
    if (rsp.pop) begin
      for (int i = 0; i < depth - 1; i++) begin
        word[i] <= word[i+1];
      end
    end
    if (rsp.write) begin
      for (int i = 0; i < depth; i++) begin
        if (idx_w'(i) == wr_idx) begin
          word[i] <= rsp.write_word;
        end
      end
    end
  end

  assign rsp.head_valid = vld[0];
  assign rsp.head_word  = word[0];

endmodule

/* hdl/parcel_align.sv */
module parcel_align (
  input  logic                       if_stall,
  input  logic                       if_flush,
  output logic [fetch_pkg::xlen-1:0] if_parcel,
  output logic [fetch_pkg::xlen-1:0] if_parcel_pc,
  output fetch_pkg::parcel_valid_t   if_parcel_valid,
  output logic                       if_parcel_misaligned,
  fetch_q_if.cons                    pcq,
  fetch_rsp_if.cons                  rsp
);

  logic               deliver;
  logic               half_sel;
  fetch_pkg::parcel_u word;
  fetch_pkg::parcel_u aligned;

  ////////////////////////////////////////////////////////////
  // delivery
  ////////////////////////////////////////////////////////////

  // pc and word heads always belong together
  assign deliver = pcq.head.valid & rsp.head_valid & ~if_stall & ~if_flush;

  // both queues advance together
  assign pcq.pop = deliver;
  assign rsp.pop = deliver;

  ////////////////////////////////////////////////////////////
  // parcel forming
  ////////////////////////////////////////////////////////////

  assign word     = rsp.head_word;
  assign half_sel = pcq.head.pc[1];

  always_comb begin
    aligned = word;
    // halfword pc takes the upper half only
    if (half_sel) begin
      aligned.half.lo = word.half.hi;
      aligned.half.hi = '0;
    end
  end

  // low half always valid and high half only for a word pc
  always_comb begin
    if_parcel_valid = '0;
    if (deliver) begin
      if_parcel_valid = half_sel ? 2'b01 : 2'b11;
    end
  end

  assign if_parcel            = aligned.full;
  assign if_parcel_pc         = pcq.head.pc;
  assign if_parcel_misaligned = pcq.head.pc[0];

endmodule

/* hdl/nocache_fetch_top.sv */
module nocache_fetch_top #(
  parameter int phys_addr_size = 32
) (
  input  logic                       clk,
  input  logic                       rstn,
  // cpu side
  input  logic [fetch_pkg::xlen-1:0] if_nxt_pc,
  output logic                       if_stall_nxt_pc,
  input  logic                       if_stall,
  input  logic                       if_flush,
  output logic [fetch_pkg::xlen-1:0] if_parcel,
  output logic [fetch_pkg::xlen-1:0] if_parcel_pc,
  output fetch_pkg::parcel_valid_t   if_parcel_valid,
  output logic                       if_parcel_misaligned,
  input  logic                       dcflush_rdy,
  input  bus_pkg::prv_t              st_prv,
  // bus side
  output logic                       biu_stb,
  input  logic                       biu_stb_ack,
  output logic [phys_addr_size-1:0]  biu_adri,
  input  logic                       biu_rack,
  input  logic [fetch_pkg::xlen-1:0] biu_do,
  output logic                       biu_is_cacheable,
  output bus_pkg::prv_t              biu_prv
);

  fetch_q_if   pcq_if ();
  fetch_rsp_if rsp_if ();

  ////////////////////////////////////////////////////////////
  // request side
  ////////////////////////////////////////////////////////////

  bus_request #(
    .phys_addr_size (phys_addr_size)
  ) bus_request_i (
    .clk              (clk),
    .rstn             (rstn),
    .if_nxt_pc        (if_nxt_pc),
    .if_flush         (if_flush),
    .dcflush_rdy      (dcflush_rdy),
    .st_prv           (st_prv),
    .if_stall_nxt_pc  (if_stall_nxt_pc),
    .biu_stb          (biu_stb),
    .biu_stb_ack      (biu_stb_ack),
    .biu_adri         (biu_adri),
    .biu_rack         (biu_rack),
    .biu_do           (biu_do),
    .biu_is_cacheable (biu_is_cacheable),
    .biu_prv          (biu_prv),
    .pcq              (pcq_if.req),
    .rsp              (rsp_if.req)
  );

  // requested pcs and returned words
  pc_queue pc_queue_i (
    .clk  (clk),
    .rstn (rstn),
    .q    (pcq_if.queue)
  );

  response_buffer response_buffer_i (
    .clk  (clk),
    .rstn (rstn),
    .rsp  (rsp_if.buffer)
  );

  ////////////////////////////////////////////////////////////
  // delivery side
  ////////////////////////////////////////////////////////////

  parcel_align parcel_align_i (
    .if_stall             (if_stall),
    .if_flush             (if_flush),
    .if_parcel            (if_parcel),
    .if_parcel_pc         (if_parcel_pc),
    .if_parcel_valid      (if_parcel_valid),
    .if_parcel_misaligned (if_parcel_misaligned),
    .pcq                  (pcq_if.cons),
    .rsp                  (rsp_if.cons)
  );

endmodule

/* dv/fetch_tb.sv */
module fetch_tb;

  localparam int clk_period   = 8;
  localparam int run_cycles   = 2000;
  localparam int drain_cycles = 60;

  logic                       clk;
  logic                       rstn;
  logic [31:0]                if_nxt_pc;
  logic                       if_stall_nxt_pc;
  logic                       if_stall;
  logic                       if_flush;
  logic [31:0]                if_parcel;
  logic [31:0]                if_parcel_pc;
  fetch_pkg::parcel_valid_t   if_parcel_valid;
  logic                       if_parcel_misaligned;
  logic                       dcflush_rdy;
  bus_pkg::prv_t              st_prv;
  logic                       biu_stb;
  logic                       biu_stb_ack;
  logic [31:0]                biu_adri;
  logic                       biu_rack;
  logic [31:0]                biu_do;
  logic                       biu_is_cacheable;
  bus_pkg::prv_t              biu_prv;

  int          seed;
  int          cyc;
  int          last_due;
  int          idle;
  logic [31:0] cur_pc;
  // pcs accepted and not yet delivered
  logic [31:0] exp_q [$];
  // pending bus reads in order
  logic [31:0] bus_adr [$];
  int          bus_due [$];

  nocache_fetch_top #(
    .phys_addr_size (32)
  ) dut_i (
    .clk                  (clk),
    .rstn                 (rstn),
    .if_nxt_pc            (if_nxt_pc),
    .if_stall_nxt_pc      (if_stall_nxt_pc),
    .if_stall             (if_stall),
    .if_flush             (if_flush),
    .if_parcel            (if_parcel),
    .if_parcel_pc         (if_parcel_pc),
    .if_parcel_valid      (if_parcel_valid),
    .if_parcel_misaligned (if_parcel_misaligned),
    .dcflush_rdy          (dcflush_rdy),
    .st_prv               (st_prv),
    .biu_stb              (biu_stb),
    .biu_stb_ack          (biu_stb_ack),
    .biu_adri             (biu_adri),
    .biu_rack             (biu_rack),
    .biu_do               (biu_do),
    .biu_is_cacheable     (biu_is_cacheable),
    .biu_prv              (biu_prv)
  );

  always #(clk_period / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////
  // error reporting and compare tasks
  ////////////////////////////////////////////////////////////

  task automatic stop_with_error(input string what);
    $display("%s", what);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_parcel(input string name, input fetch_pkg::parcel_u got,
                              input fetch_pkg::parcel_u exp);
    if (got.full !== exp.full) begin
      stop_with_error($sformatf("mismatch %s: got %h expected %h", name, got.full, exp.full));
    end
  endtask

  task automatic check_pc(input string name, input logic [fetch_pkg::xlen-1:0] got,
                          input logic [fetch_pkg::xlen-1:0] exp);
    if (got !== exp) begin
      stop_with_error($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_valid(input string name, input fetch_pkg::parcel_valid_t got,
                             input fetch_pkg::parcel_valid_t exp);
    if (got !== exp) begin
      stop_with_error($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_error($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_prv(input string name, input bus_pkg::prv_t got,
                           input bus_pkg::prv_t exp);
    if (got !== exp) begin
      stop_with_error($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // memory contents and pc sequence
  ////////////////////////////////////////////////////////////

  // memory word scrambled from the full word address
  function automatic logic [31:0] scramble(input logic [31:0] addr);
    logic [31:0] w;
    w = {2'b00, addr[31:2]};
    return (w * 32'h9e37_79b1) ^ {w[15:0], w[31:16]} ^ 32'h5a3c_c3a5;
  endfunction

  // mostly sequential with jumps and halfword steps
  function automatic logic [31:0] next_pc(input logic [31:0] pc);
    int r;
    r = $random(seed);
    if ((r & 7) == 0) begin
      next_pc = $random(seed);
    end else if ((r & 7) == 1) begin
      next_pc = {pc[31:2] + 30'd1, 2'b10};
    end else begin
      next_pc = {pc[31:2] + 30'd1, 2'b00};
    end
  endfunction

  ////////////////////////////////////////////////////////////
  // per-cycle stimulus and checking
  ////////////////////////////////////////////////////////////

  // quiet cycles have no issue, no stall and no flush
  task automatic drive_cycle(input bit quiet);
    int r;
    // rack the oldest read once its latency is up
    biu_rack = 1'b0;
    biu_do   = 32'h0;
    if (bus_due.size() > 0 && bus_due[0] <= cyc) begin
      biu_rack = 1'b1;
      biu_do   = scramble(bus_adr.pop_front());
      void'(bus_due.pop_front());
    end
    r = $random(seed);
    biu_stb_ack = (r & 3) != 0;
    st_prv      = bus_pkg::prv_t'(r[5:4]);
    r = $random(seed);
    if (quiet) begin
      dcflush_rdy = 1'b0;
      if_stall    = 1'b0;
      if_flush    = 1'b0;
    end else begin
      dcflush_rdy = (r & 15) != 0;
      if_stall    = ((r >> 4) & 7) < 2;
      if_flush    = ((r >> 8) & 63) == 0;
    end
    if_nxt_pc = cur_pc;
  endtask

  task automatic check_cycle();
    logic [31:0]        pc;
    logic [31:0]        word;
    fetch_pkg::parcel_u exp_parcel;
    logic               exp_stb;
    int                 lat;
    // issue only with room in the pc queue
    exp_stb = dcflush_rdy & ~if_flush & (exp_q.size() < 3);
    check_flag("biu_stb", biu_stb, exp_stb);
    if (if_stall || if_flush) begin
      check_valid("if_parcel_valid", if_parcel_valid, 2'b00);
    end
    // delivered parcel against the oldest pc
    if (if_parcel_valid != 2'b00) begin
      if (exp_q.size() == 0) begin
        stop_with_error("a parcel was delivered with no request pending");
      end else begin
        pc   = exp_q.pop_front();
        word = scramble(pc);
        // halfword pc gets the upper half in the low position
        exp_parcel.full = pc[1] ? {16'h0000, word[31:16]} : word;
        check_pc("if_parcel_pc", if_parcel_pc, pc);
        check_parcel("if_parcel", if_parcel, exp_parcel);
        check_valid("if_parcel_valid", if_parcel_valid, pc[1] ? 2'b01 : 2'b11);
        check_flag("if_parcel_misaligned", if_parcel_misaligned, pc[0]);
      end
    end
    if (if_flush) begin
      exp_q.delete();
    end
    // accepted request and its attributes
    if (biu_stb && biu_stb_ack) begin
      check_flag("if_stall_nxt_pc", if_stall_nxt_pc, 1'b0);
      check_pc("biu_adri", biu_adri, cur_pc);
      check_flag("biu_is_cacheable", biu_is_cacheable, ~cur_pc[31]);
      check_prv("biu_prv", biu_prv, st_prv);
      exp_q.push_back(cur_pc);
      // 1 to 4 cycles and never before an older read
      lat      = 1 + ($random(seed) & 3);
      last_due = (cyc + lat > last_due) ? cyc + lat : last_due + 1;
      bus_adr.push_back(cur_pc);
      bus_due.push_back(last_due);
      cur_pc = next_pc(cur_pc);
    end else begin
      check_flag("if_stall_nxt_pc", if_stall_nxt_pc, 1'b1);
    end
  endtask

  task automatic run_cycle(input bit quiet);
    cyc = cyc + 1;
    @(posedge clk);
    #1;
    drive_cycle(quiet);
    @(negedge clk);
    check_cycle();
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    seed        = 72;
    clk         = 1'b0;
    rstn        = 1'b0;
    if_nxt_pc   = 32'h0;
    if_stall    = 1'b0;
    if_flush    = 1'b0;
    dcflush_rdy = 1'b0;
    st_prv      = bus_pkg::prv_m;
    biu_stb_ack = 1'b0;
    biu_rack    = 1'b0;
    biu_do      = 32'h0;
    cur_pc      = 32'h0000_1000;
    cyc         = 0;
    last_due    = 0;
    idle        = 0;
    repeat (3) @(posedge clk);
    #1 rstn = 1'b1;
    // no issue until dcflush_rdy
    for (int i = 0; i < 4; i++) begin
      run_cycle(1'b1);
    end
    for (int i = 0; i < run_cycles; i++) begin
      run_cycle(1'b0);
    end
    // let the bus and both queues empty out
    while ((exp_q.size() > 0 || bus_due.size() > 0) && idle < drain_cycles) begin
      run_cycle(1'b1);
      idle = idle + 1;
    end
    if (exp_q.size() != 0) begin
      stop_with_error("requests were never delivered after the bus went idle");
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

  initial begin
    #((run_cycles + drain_cycles + 100) * clk_period);
    stop_with_error("watchdog timeout, the run did not finish in time");
  end

endmodule

/* list.f */
hdl/fetch_pkg.sv
hdl/bus_pkg.sv
hdl/fetch_if.sv
hdl/bus_request.sv
hdl/pc_queue.sv
hdl/response_buffer.sv
hdl/parcel_align.sv
hdl/nocache_fetch_top.sv
dv/fetch_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the fetch testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module fetch_tb -f list.f -Mdir obj_dir -o fetch_sim

out=$(./obj_dir/fetch_sim 2>&1) || true
echo "$out"

if grep -q "PASS: all tests" <<< "$out"; then
  exit 0
else
  exit 1
fi
